// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_instr_dec
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)

// File: design/access_ctrl_if.sv
interface access_ctrl_if;
	logic mem_wr;   // Data memory write
	logic dsp_push; // Data stack push
	logic dsp_pop;  // Data stack pop
	logic ldi;      // Indirect load
	logic fft_ld;   // Bit-reversed load address

	modport src (
		output mem_wr,
		output dsp_push,
		output dsp_pop,
		output ldi,
		output fft_ld
	);

	// Issue side only needs the load half of the bit-reverse flag
	modport snk (
		input fft_ld
	);
endinterface

// File: design/access_decoder.sv
module access_decoder #(
	parameter int opcode_width = instr_dec_pkg::opcode_width_d
) (
	input instr_dec_pkg::opcode_e opcode,
	access_ctrl_if.src            acc
);
	import instr_dec_pkg::*;

	if (opcode_width != $bits(opcode_e)) begin : g_width_chk
		$error("opcode_width does not match the opcode encoding");
	end

	// Same-cycle memory and stack strobes
	always_comb begin
		acc.mem_wr   = 1'b0;
		acc.dsp_push = 1'b0;
		acc.dsp_pop  = 1'b0;
		acc.ldi      = 1'b0;
		acc.fft_ld   = 1'b0;
		case (opcode)
			// Accumulator goes to the stack before the memory operand is used
			op_p_lod,
			op_psh,
			op_p_neg_m,
			op_p_abs_m,
			op_p_pst_m,
			op_p_nrm_m,
			op_p_inv_m,
			op_p_lin_m: begin
				acc.mem_wr   = 1'b1;
				acc.dsp_push = 1'b1;
			end
			op_set: begin
				acc.mem_wr = 1'b1;
			end
			op_set_p: begin
				acc.mem_wr  = 1'b1;
				acc.dsp_pop = 1'b1;
			end
			op_sti,
			op_isi,
			op_pop,
			op_out: begin
				acc.dsp_pop = 1'b1;                    // Index or value taken off the stack
			end
			// Stack-operand ALU forms
			op_s_add,
			op_s_mlt,
			op_s_div,
			op_s_mod,
			op_s_sgn,
			op_s_and,
			op_s_orr,
			op_s_xor,
			op_s_lan,
			op_s_lor,
			op_s_les,
			op_sf_les,
			op_s_gre,
			op_sf_gre,
			op_s_equ,
			op_s_shl,
			op_s_shr,
			op_s_srs: begin
				acc.dsp_pop = 1'b1;
			end
			op_ldi: begin
				acc.ldi = 1'b1;
			end
			op_ili: begin
				acc.ldi    = 1'b1;
				acc.fft_ld = 1'b1;                     // Reverse offset bits
			end
			default: begin
				acc.mem_wr = 1'b0;                     // Flow control, plain forms, unused codes
			end
		endcase

		// No opcode moves the stack both ways
		assert (!(acc.dsp_push && acc.dsp_pop))
			else $error("push and pop decoded together for opcode %0d", opcode);
	end

endmodule

// File: design/instr_dec_pkg.sv
package instr_dec_pkg;

	// Top level defaults
	localparam int data_width_d     = 32;
	localparam int opcode_width_d   = 7;
	localparam int operand_width_d  = 9;
	localparam int mem_addr_width_d = 8;

	localparam int alu_op_width = 6;

	// Integer instruction set, float and conversion opcodes left out
	typedef enum logic [opcode_width_d-1:0] {
		op_lod     = 7'd0,                      // Load accumulator from memory
		op_p_lod   = 7'd1,                      // Push, then load
		op_ldi     = 7'd2,                      // Indirect load, offset in accumulator
		op_ili     = 7'd3,                      // Indirect load, bit-reversed
		op_set     = 7'd4,                      // Store accumulator
		op_set_p   = 7'd5,                      // Store and pop
		op_sti     = 7'd6,                      // Indirect store, index on stack
		op_isi     = 7'd7,                      // Indirect store, bit-reversed
		op_psh     = 7'd8,
		op_pop     = 7'd9,
		op_inn     = 7'd10,                     // Read I/O input
		op_out     = 7'd11,                     // Write I/O output
		op_jmp     = 7'd12,                     // Flow control handled by prefetch
		op_jiz     = 7'd13,
		op_cal     = 7'd14,
		op_ret     = 7'd15,
		op_add     = 7'd16, op_s_add   = 7'd17,
		op_mlt     = 7'd20, op_s_mlt   = 7'd21,
		op_div     = 7'd24, op_s_div   = 7'd25,
		op_mod     = 7'd28, op_s_mod   = 7'd29,
		op_sgn     = 7'd30, op_s_sgn   = 7'd31,
		op_neg     = 7'd34,
		op_neg_m   = 7'd35, op_p_neg_m = 7'd36,
		op_abs     = 7'd40,
		op_abs_m   = 7'd41, op_p_abs_m = 7'd42,
		op_pst     = 7'd46,                     // Clamp negative to zero
		op_pst_m   = 7'd47, op_p_pst_m = 7'd48,
		op_nrm     = 7'd52,                     // Divide by constant
		op_nrm_m   = 7'd53, op_p_nrm_m = 7'd54,
		op_and     = 7'd61, op_s_and   = 7'd62,
		op_orr     = 7'd63, op_s_orr   = 7'd64,
		op_xor     = 7'd65, op_s_xor   = 7'd66,
		op_inv     = 7'd67,
		op_inv_m   = 7'd68, op_p_inv_m = 7'd69,
		op_lan     = 7'd70, op_s_lan   = 7'd71, // Logical and
		op_lor     = 7'd72, op_s_lor   = 7'd73, // Logical or
		op_lin     = 7'd74,                     // Logical invert
		op_lin_m   = 7'd75, op_p_lin_m = 7'd76,
		op_les     = 7'd77, op_s_les   = 7'd78,
		op_f_les   = 7'd79, op_sf_les  = 7'd80,
		op_gre     = 7'd81, op_s_gre   = 7'd82,
		op_f_gre   = 7'd83, op_sf_gre  = 7'd84,
		op_equ     = 7'd85, op_s_equ   = 7'd86,
		op_shl     = 7'd87, op_s_shl   = 7'd88,
		op_shr     = 7'd89, op_s_shr   = 7'd90,
		op_srs     = 7'd91, op_s_srs   = 7'd92  // Arithmetic shift right
	} opcode_e;

	// ALU codes keep their original numbering
	typedef enum logic [alu_op_width-1:0] {
		alu_pass_zero = 6'd0,
		alu_pass_data = 6'd1,
		alu_add       = 6'd2,
		alu_mlt       = 6'd4,
		alu_div       = 6'd6,
		alu_mod       = 6'd8,
		alu_sgn       = 6'd9,
		alu_neg       = 6'd11,
		alu_neg_m     = 6'd12,
		alu_abs       = 6'd15,
		alu_abs_m     = 6'd16,
		alu_pst       = 6'd19,
		alu_pst_m     = 6'd20,
		alu_nrm       = 6'd23,
		alu_nrm_m     = 6'd24,
		alu_and       = 6'd29,
		alu_orr       = 6'd30,
		alu_xor       = 6'd31,
		alu_inv       = 6'd32,
		alu_inv_m     = 6'd33,
		alu_lan       = 6'd34,
		alu_lor       = 6'd35,
		alu_lin       = 6'd36,
		alu_lin_m     = 6'd37,
		alu_les       = 6'd38,
		alu_f_les     = 6'd39,
		alu_gre       = 6'd40,
		alu_f_gre     = 6'd41,
		alu_equ       = 6'd42,
		alu_shl       = 6'd43,
		alu_shr       = 6'd44,
		alu_srs       = 6'd45
	} alu_op_e;

	// Issue stage state after reset
	localparam alu_op_e ula_op_rst = alu_pass_zero;
	localparam logic    ctrl_rst   = 1'b0;

endpackage

// File: design/instr_dec_top.sv
module instr_dec_top #(
	parameter int data_width     = instr_dec_pkg::data_width_d,
	parameter int opcode_width   = instr_dec_pkg::opcode_width_d,
	parameter int operand_width  = instr_dec_pkg::operand_width_d,
	parameter int mem_addr_width = instr_dec_pkg::mem_addr_width_d
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic [opcode_width-1:0]                opcode,
	input  logic [operand_width-1:0]               operand,
	input  logic [data_width-1:0]                  mem_data_in,
	input  logic [data_width-1:0]                  io_in,
	output logic                                   dsp_push,
	output logic                                   dsp_pop,
	output logic                                   mem_wr,
	output logic                                   ldi,
	output logic                                   sti,
	output logic                                   fft,
	output logic                                   req_in,
	output logic                                   out_en,
	output logic [instr_dec_pkg::alu_op_width-1:0] ula_op,
	output logic [data_width-1:0]                  ula_data,
	output logic [mem_addr_width-1:0]              mem_addr
);
	import instr_dec_pkg::*;

	opcode_e opcode_dec;   // Raw opcode bits seen as the instruction enum

	access_ctrl_if acc ();

	assign opcode_dec = opcode_e'(opcode);

	access_decoder #(
		.opcode_width (opcode_width)
	) u_access_decoder (
		.opcode (opcode_dec),
		.acc    (acc.src)
	);

	issue_decoder #(
		.data_width   (data_width),
		.opcode_width (opcode_width)
	) u_issue_decoder (
		.clk         (clk),
		.rst         (rst),
		.opcode      (opcode_dec),
		.mem_data_in (mem_data_in),
		.io_in       (io_in),
		.acc         (acc.snk),
		.ula_op      (ula_op),
		.sti         (sti),
		.req_in      (req_in),
		.out_en      (out_en),
		.fft         (fft),
		.ula_data    (ula_data)
	);

	assign mem_wr   = acc.mem_wr;
	assign dsp_push = acc.dsp_push;
	assign dsp_pop  = acc.dsp_pop;
	assign ldi      = acc.ldi;

	// Direct addressing from the operand field
	assign mem_addr = operand[mem_addr_width-1:0];

endmodule

// File: design/issue_decoder.sv
module issue_decoder #(
	parameter int data_width   = instr_dec_pkg::data_width_d,
	parameter int opcode_width = instr_dec_pkg::opcode_width_d
) (
	input  logic                    clk,
	input  logic                    rst,
	input  instr_dec_pkg::opcode_e  opcode,
	input  logic [data_width-1:0]   mem_data_in,
	input  logic [data_width-1:0]   io_in,
	access_ctrl_if.snk              acc,
	output instr_dec_pkg::alu_op_e  ula_op,
	output logic                    sti,
	output logic                    req_in,
	output logic                    out_en,
	output logic                    fft,
	output logic [data_width-1:0]   ula_data
);
	import instr_dec_pkg::*;

	alu_op_e alu_nxt;
	logic    sti_nxt;
	logic    fft_st_nxt;
	logic    req_in_nxt;
	logic    out_en_nxt;
	logic    fft_st;     // Bit-reversed store, one cycle behind decode

	if (opcode_width != $bits(opcode_e)) begin : g_width_chk
		$error("opcode_width does not match the opcode encoding");
	end

	always_comb begin
		alu_nxt    = alu_pass_zero;
		sti_nxt    = 1'b0;
		fft_st_nxt = 1'b0;
		req_in_nxt = 1'b0;
		out_en_nxt = 1'b0;
		case (opcode)
			op_lod, op_p_lod, op_ldi, op_ili,
			op_set_p, op_pop: alu_nxt = alu_pass_data; // Memory word to accumulator
			op_inn: begin
				alu_nxt    = alu_pass_data;
				req_in_nxt = 1'b1;
			end
			op_sti: sti_nxt = 1'b1;
			op_isi: begin
				sti_nxt    = 1'b1;
				fft_st_nxt = 1'b1;
			end
			op_out: out_en_nxt = 1'b1;
			op_add, op_s_add: alu_nxt = alu_add;
			op_mlt, op_s_mlt: alu_nxt = alu_mlt;
			op_div, op_s_div: alu_nxt = alu_div;
			op_mod, op_s_mod: alu_nxt = alu_mod;
			op_sgn, op_s_sgn: alu_nxt = alu_sgn;
			op_neg: alu_nxt = alu_neg;
			op_neg_m, op_p_neg_m: alu_nxt = alu_neg_m;
			op_abs: alu_nxt = alu_abs;
			op_abs_m, op_p_abs_m: alu_nxt = alu_abs_m;
			op_pst: alu_nxt = alu_pst;
			op_pst_m, op_p_pst_m: alu_nxt = alu_pst_m;
			op_nrm: alu_nxt = alu_nrm;
			op_nrm_m, op_p_nrm_m: alu_nxt = alu_nrm_m;
			op_and, op_s_and: alu_nxt = alu_and;
			op_orr, op_s_orr: alu_nxt = alu_orr;
			op_xor, op_s_xor: alu_nxt = alu_xor;
			op_inv: alu_nxt = alu_inv;
			op_inv_m, op_p_inv_m: alu_nxt = alu_inv_m;
			op_lan, op_s_lan: alu_nxt = alu_lan;
			op_lor, op_s_lor: alu_nxt = alu_lor;
			op_lin: alu_nxt = alu_lin;
			op_lin_m, op_p_lin_m: alu_nxt = alu_lin_m;
			op_les, op_s_les: alu_nxt = alu_les;
			op_f_les, op_sf_les: alu_nxt = alu_f_les;
			op_gre, op_s_gre: alu_nxt = alu_gre;
			op_f_gre, op_sf_gre: alu_nxt = alu_f_gre;
			op_equ, op_s_equ: alu_nxt = alu_equ;
			op_shl, op_s_shl: alu_nxt = alu_shl;
			op_shr, op_s_shr: alu_nxt = alu_shr;
			op_srs, op_s_srs: alu_nxt = alu_srs;
			default: alu_nxt = alu_pass_zero;            // SET, PSH, flow control and no-ops
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ula_op <= ula_op_rst;
			sti    <= ctrl_rst;
			fft_st <= ctrl_rst;
			req_in <= ctrl_rst;
			out_en <= ctrl_rst;
		end else begin
			ula_op <= alu_nxt;
			sti    <= sti_nxt;
			fft_st <= fft_st_nxt;
			req_in <= req_in_nxt;
			out_en <= out_en_nxt;
		end
	end

	assign fft = acc.fft_ld | fft_st;               // Load side is same cycle, store side registered

	// I/O word replaces the memory word while an INN is being issued
	assign ula_data = req_in ? io_in : mem_data_in;

	// Input and output never issue in the same cycle
	a_io_excl : assert property (@(posedge clk) disable iff (rst) !(req_in && out_en));

	// Bit-reversed store only ever rides on an indirect store
	a_fft_st_sti : assert property (@(posedge clk) disable iff (rst) fft_st |-> sti);

endmodule

// File: files.f
+incdir+sim
design/instr_dec_pkg.sv
design/access_ctrl_if.sv
design/access_decoder.sv
design/issue_decoder.sv
design/instr_dec_top.sv
sim/tb_instr_dec.sv

// File: sim/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Expected decoder controls for one opcode
typedef struct packed {
	logic       mem_wr;
	logic       dsp_push;
	logic       dsp_pop;
	logic       ldi;
	logic       fft_ld;
	logic [5:0] alu;     // ALU code issued on the next cycle
	logic       sti;
	logic       fft_st;
	logic       req_in;
	logic       out_en;
} exp_ctrl_t;

function automatic exp_ctrl_t ref_decode(input logic [6:0] op);
	exp_ctrl_t e;
	int        n;
	e = '0;
	n = int'(op);
	case (n)
		0: e.alu = 6'd1;                      // LOD
		1: begin                              // P_LOD
			e.mem_wr   = 1'b1;
			e.dsp_push = 1'b1;
			e.alu      = 6'd1;
		end
		2: begin                              // LDI
			e.ldi = 1'b1;
			e.alu = 6'd1;
		end
		3: begin                              // ILI
			e.ldi    = 1'b1;
			e.fft_ld = 1'b1;
			e.alu    = 6'd1;
		end
		4: e.mem_wr = 1'b1;                   // SET
		5: begin                              // SET_P
			e.mem_wr  = 1'b1;
			e.dsp_pop = 1'b1;
			e.alu     = 6'd1;
		end
		6: begin                              // STI
			e.dsp_pop = 1'b1;
			e.sti     = 1'b1;
		end
		7: begin                              // ISI
			e.dsp_pop = 1'b1;
			e.sti     = 1'b1;
			e.fft_st  = 1'b1;
		end
		8: begin                              // PSH
			e.mem_wr   = 1'b1;
			e.dsp_push = 1'b1;
		end
		9: begin                              // POP
			e.dsp_pop = 1'b1;
			e.alu     = 6'd1;
		end
		10: begin                             // INN
			e.req_in = 1'b1;
			e.alu    = 6'd1;
		end
		11: begin                             // OUT
			e.dsp_pop = 1'b1;
			e.out_en  = 1'b1;
		end
		16, 17: e.alu = 6'd2;
		20, 21: e.alu = 6'd4;
		24, 25: e.alu = 6'd6;
		28, 29: e.alu = 6'd8;
		30, 31: e.alu = 6'd9;
		34: e.alu = 6'd11;
		35, 36: e.alu = 6'd12;
		40: e.alu = 6'd15;
		41, 42: e.alu = 6'd16;
		46: e.alu = 6'd19;
		47, 48: e.alu = 6'd20;
		52: e.alu = 6'd23;
		53, 54: e.alu = 6'd24;
		61, 62: e.alu = 6'd29;
		63, 64: e.alu = 6'd30;
		65, 66: e.alu = 6'd31;
		67: e.alu = 6'd32;
		68, 69: e.alu = 6'd33;
		70, 71: e.alu = 6'd34;
		72, 73: e.alu = 6'd35;
		74: e.alu = 6'd36;
		75, 76: e.alu = 6'd37;
		77, 78: e.alu = 6'd38;
		79, 80: e.alu = 6'd39;
		81, 82: e.alu = 6'd40;
		83, 84: e.alu = 6'd41;
		85, 86: e.alu = 6'd42;
		87, 88: e.alu = 6'd43;
		89, 90: e.alu = 6'd44;
		91, 92: e.alu = 6'd45;
		default: e = '0;                      // Flow control, dropped and unused codes
	endcase
	// Stack operand forms pop their second operand
	if (n inside {17, 21, 25, 29, 31, 62, 64, 66, 71, 73, 78, 80, 82, 84, 86, 88, 90, 92})
		e.dsp_pop = 1'b1;
	// Push-first memory forms save the accumulator
	if (n inside {36, 42, 48, 54, 69, 76}) begin
		e.mem_wr   = 1'b1;
		e.dsp_push = 1'b1;
	end
	return e;
endfunction

`endif

// File: sim/tb_instr_dec.sv
module tb_instr_dec;
	localparam int data_width     = 32;
	localparam int opcode_width   = 7;
	localparam int operand_width  = 9;
	localparam int mem_addr_width = 8;
	localparam int clk_period     = 4;
	localparam int rst_cycles     = 3;
	localparam int n_sweep        = 128;
	localparam int n_addr         = 32;
	localparam int n_rand         = 500;
	localparam int total_cycles   = rst_cycles + 1 + n_sweep + n_addr + n_rand + 4;
	localparam logic [6:0] noop_op = 7'd100;

	`include "tb_ref.svh"

	logic                      clk = 1'b0;
	logic                      rst;
	logic [opcode_width-1:0]   opcode;
	logic [operand_width-1:0]  operand;
	logic [data_width-1:0]     mem_data_in;
	logic [data_width-1:0]     io_in;
	logic                      dsp_push;
	logic                      dsp_pop;
	logic                      mem_wr;
	logic                      ldi;
	logic                      sti;
	logic                      fft;
	logic                      req_in;
	logic                      out_en;
	logic [5:0]                ula_op;
	logic [data_width-1:0]     ula_data;
	logic [mem_addr_width-1:0] mem_addr;

	integer    seed = 32'h69b6;
	integer    r;
	int        i;
	int        checks = 0;
	int        errors = 0;
	exp_ctrl_t iss_exp = '0;   // Issue side expectation lags one cycle
	logic [6:0] iss_op = '0;

	instr_dec_top #(
		.data_width     (data_width),
		.opcode_width   (opcode_width),
		.operand_width  (operand_width),
		.mem_addr_width (mem_addr_width)
	) dut0 (
		.clk         (clk),
		.rst         (rst),
		.opcode      (opcode),
		.operand     (operand),
		.mem_data_in (mem_data_in),
		.io_in       (io_in),
		.dsp_push    (dsp_push),
		.dsp_pop     (dsp_pop),
		.mem_wr      (mem_wr),
		.ldi         (ldi),
		.sti         (sti),
		.fft         (fft),
		.req_in      (req_in),
		.out_en      (out_en),
		.ula_op      (ula_op),
		.ula_data    (ula_data),
		.mem_addr    (mem_addr)
	);

	always #(clk_period / 2) clk = ~clk;

	// Opcode seen at the edge sets what issues next
	always @(posedge clk) begin
		iss_exp <= rst ? '0 : ref_decode(opcode);
		iss_op  <= opcode;
	end

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		exp_ctrl_t             a;
		logic [data_width-1:0] data_exp;
		a = ref_decode(opcode);
		data_exp = iss_exp.req_in ? io_in : mem_data_in;
		checks++;
		assert ({mem_wr, dsp_push, dsp_pop, ldi} == {a.mem_wr, a.dsp_push, a.dsp_pop, a.ldi})
		else begin
			errors++;
			$display("** Error at %0t: opcode %0d access controls %b, expected %b", $time,
				opcode, {mem_wr, dsp_push, dsp_pop, ldi},
				{a.mem_wr, a.dsp_push, a.dsp_pop, a.ldi});
		end
		assert (ula_op == iss_exp.alu && {sti, req_in, out_en} ==
			{iss_exp.sti, iss_exp.req_in, iss_exp.out_en})
		else begin
			errors++;
			$display("** Error at %0t: opcode %0d issued alu %0d sti/req/out %b, expected %0d %b",
				$time, iss_op, ula_op, {sti, req_in, out_en}, iss_exp.alu,
				{iss_exp.sti, iss_exp.req_in, iss_exp.out_en});
		end
		assert (fft == (a.fft_ld | iss_exp.fft_st))
		else begin
			errors++;
			$display("** Error at %0t: fft %b, expected %b", $time, fft,
				a.fft_ld | iss_exp.fft_st);
		end
		assert (mem_addr == operand[mem_addr_width-1:0])
		else begin
			errors++;
			$display("** Error at %0t: mem_addr %h for operand %h", $time, mem_addr, operand);
		end
		assert (ula_data == data_exp)
		else begin
			errors++;
			$display("** Error at %0t: ula_data %h, expected %h", $time, ula_data, data_exp);
		end
	end

	task automatic drive_cycle(input logic [6:0] op);
		integer v;
		@(posedge clk);
		#1;
		opcode = op;
		v = $random(seed);
		operand = v[operand_width-1:0];
		mem_data_in = $random(seed);
		io_in = $random(seed);
	endtask

	task automatic check_reset_state();
		assert (ula_op == 6'd0 && {sti, req_in, out_en, fft} == 4'b0000)
		else begin
			errors++;
			$display("** Error at %0t: state after reset alu %0d sti/req/out/fft %b", $time,
				ula_op, {sti, req_in, out_en, fft});
		end
	endtask

	initial begin
		rst = 1'b1;
		opcode = noop_op;
		operand = '0;
		mem_data_in = '0;
		io_in = '0;
		repeat (rst_cycles) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_reset_state();
		for (i = 0; i < n_sweep; i++)
			drive_cycle(i[6:0]);                   // Every opcode in turn
		for (i = 0; i < n_addr; i++)
			drive_cycle(noop_op);                  // Operand and data only
		for (i = 0; i < n_rand; i++) begin
			r = $random(seed);
			drive_cycle(r[6:0]);
		end
		drive_cycle(noop_op);
		@(negedge clk);
		@(negedge clk);
		#1;                                        // Last checker pass lands before the summary
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		#(total_cycles * clk_period + 100);
		$display("Timeout: the run did not finish within %0d cycles", total_cycles);
		$display("TB FAILED");
		$finish;
	end

endmodule
